// File: common/exe_pkg.sv
`default_nettype none

package exe_pkg;

    localparam int XLEN = 32;
    localparam int PREG_NUM = 32;
    localparam int ROB_W = 5;

    typedef logic [XLEN-1:0] xdata_t;
    typedef logic [$clog2(PREG_NUM)-1:0] preg_idx_t;
    typedef logic [ROB_W-1:0] rob_idx_t;

    // shifts take b[4:0], SLT is signed
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT
    } alu_op_e;

endpackage

`default_nettype wire

// File: common/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if;

    logic issue_vld;
    exe_pkg::alu_op_e op;
    exe_pkg::xdata_t a;
    exe_pkg::xdata_t b;
    exe_pkg::preg_idx_t dst;
    logic wen;
    exe_pkg::rob_idx_t rob;
    // alu holds this until its result has left
    logic busy;

    modport iq (
        output issue_vld, op, a, b, dst, wen, rob,
        input busy
    );

    modport fu (
        input issue_vld, op, a, b, dst, wen, rob,
        output busy
    );

endinterface

`default_nettype wire

// File: common/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

    // four-phase, payload stable while req is high
    logic req;
    logic ack;
    exe_pkg::preg_idx_t dst;
    logic wen;
    exe_pkg::rob_idx_t rob;
    exe_pkg::xdata_t data;

    modport fu (output req, dst, wen, rob, data, input ack);

    modport arb (input req, dst, wen, rob, data, output ack);

endinterface

`default_nettype wire

// File: regfile/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile #(
    parameter int FU_NUM = 3
) (
    input logic clk,
    input logic i_reset,

    input logic i_mark_vld,
    input exe_pkg::preg_idx_t i_mark_idx,

    input exe_pkg::preg_idx_t i_check_idx [2],
    output logic [1:0] o_check_rdy,

    input exe_pkg::preg_idx_t i_read_idx [2*FU_NUM],
    output exe_pkg::xdata_t o_read_data [2*FU_NUM],

    input logic i_write_en,
    input exe_pkg::preg_idx_t i_write_idx,
    input exe_pkg::xdata_t i_write_data
);

    exe_pkg::xdata_t regs [exe_pkg::PREG_NUM];
    logic [exe_pkg::PREG_NUM-1:0] ready_q;

    // register 0 is never written and never marked
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ready_q <= '1;
            for (int r = 0; r < exe_pkg::PREG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (i_write_en && i_write_idx != '0) begin
                regs[i_write_idx] <= i_write_data;
                ready_q[i_write_idx] <= 1'b1;
            end
            if (i_mark_vld && i_mark_idx != '0) begin
                ready_q[i_mark_idx] <= 1'b0;
            end
        end
    end

    // same-cycle write counts as ready
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            o_check_rdy[k] = ready_q[i_check_idx[k]] ||
                             (i_write_en && i_write_idx == i_check_idx[k]);
        end
    end

    always_comb begin
        for (int p = 0; p < 2*FU_NUM; p++) begin
            o_read_data[p] = (i_read_idx[p] == '0) ? '0 : regs[i_read_idx[p]];
        end
    end

endmodule

`default_nettype wire

// File: issue/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
    parameter int FU_NUM = 3,
    parameter int IQ_DEPTH = 8
) (
    input logic clk,
    input logic i_reset,

    input logic i_disp_valid,
    output logic o_disp_ready,
    input exe_pkg::alu_op_e i_disp_op,
    input exe_pkg::preg_idx_t i_disp_src1,
    input exe_pkg::preg_idx_t i_disp_src2,
    input logic i_disp_use_imm,
    input exe_pkg::xdata_t i_disp_imm,
    input exe_pkg::preg_idx_t i_disp_dst,
    input logic i_disp_wen,
    input exe_pkg::rob_idx_t i_disp_rob,

    output logic o_mark_vld,
    output exe_pkg::preg_idx_t o_mark_idx,
    output exe_pkg::preg_idx_t o_check_idx [2],
    input logic [1:0] i_check_rdy,

    output exe_pkg::preg_idx_t o_read_idx [2*FU_NUM],
    input exe_pkg::xdata_t i_read_data [2*FU_NUM],

    input logic i_wake_vld,
    input exe_pkg::preg_idx_t i_wake_idx,

    issue_if.iq o_issue [FU_NUM]
);

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    typedef enum logic {
        FREE,
        WAITING
    } iq_state_e;

    typedef logic [7:0] age_t;

    genvar f;

    iq_state_e ent_state [IQ_DEPTH];
    age_t ent_age [IQ_DEPTH];
    logic [1:0] ent_rdy [IQ_DEPTH];
    exe_pkg::preg_idx_t ent_src [IQ_DEPTH][2];
    logic ent_use_imm [IQ_DEPTH];
    exe_pkg::xdata_t ent_imm [IQ_DEPTH];
    exe_pkg::alu_op_e ent_op [IQ_DEPTH];
    exe_pkg::preg_idx_t ent_dst [IQ_DEPTH];
    logic ent_wen [IQ_DEPTH];
    exe_pkg::rob_idx_t ent_rob [IQ_DEPTH];

    logic [IQ_DEPTH-1:0] cand;
    logic [IQ_DEPTH-1:0] issue_mask;
    logic [FU_NUM-1:0] fu_busy;
    logic [FU_NUM-1:0] sel_vld;
    logic [IDX_W-1:0] sel_idx [FU_NUM];
    logic free_vld;
    logic [IDX_W-1:0] free_idx;
    logic disp_fire;

    // lowest free slot
    always_comb begin
        free_vld = 1'b0;
        free_idx = '0;
        for (int e = IQ_DEPTH - 1; e >= 0; e--) begin
            if (ent_state[e] == FREE) begin
                free_vld = 1'b1;
                free_idx = IDX_W'(e);
            end
        end
    end

    assign o_disp_ready = free_vld;
    assign disp_fire = i_disp_valid && free_vld;
    assign o_mark_vld = disp_fire && i_disp_wen && i_disp_dst != '0;
    assign o_mark_idx = i_disp_dst;
    assign o_check_idx[0] = i_disp_src1;
    assign o_check_idx[1] = i_disp_src2;

    always_comb begin
        for (int e = 0; e < IQ_DEPTH; e++) begin
            cand[e] = (ent_state[e] == WAITING) && (&ent_rdy[e]);
        end
    end

    // each free alu in order takes the oldest candidate left
    always_comb begin : select
        age_t best_age;
        issue_mask = '0;
        best_age = '0;
        for (int u = 0; u < FU_NUM; u++) begin
            sel_vld[u] = 1'b0;
            sel_idx[u] = '0;
            best_age = '0;
            if (!fu_busy[u]) begin
                for (int e = 0; e < IQ_DEPTH; e++) begin
                    if (cand[e] && !issue_mask[e] && (!sel_vld[u] || ent_age[e] > best_age)) begin
                        sel_vld[u] = 1'b1;
                        sel_idx[u] = IDX_W'(e);
                        best_age = ent_age[e];
                    end
                end
            end
            if (sel_vld[u]) begin
                issue_mask[sel_idx[u]] = 1'b1;
            end
        end
    end

    generate
        for (f = 0; f < FU_NUM; f = f + 1) begin : gen_issue
            assign fu_busy[f] = o_issue[f].busy;
            assign o_read_idx[2*f] = ent_src[sel_idx[f]][0];
            assign o_read_idx[2*f+1] = ent_src[sel_idx[f]][1];
            assign o_issue[f].issue_vld = sel_vld[f];
            assign o_issue[f].op = ent_op[sel_idx[f]];
            assign o_issue[f].a = i_read_data[2*f];
            assign o_issue[f].b = ent_use_imm[sel_idx[f]] ? ent_imm[sel_idx[f]]
                                                          : i_read_data[2*f+1];
            assign o_issue[f].dst = ent_dst[sel_idx[f]];
            assign o_issue[f].wen = ent_wen[sel_idx[f]];
            assign o_issue[f].rob = ent_rob[sel_idx[f]];
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int e = 0; e < IQ_DEPTH; e++) begin
                ent_state[e] <= FREE;
                ent_age[e] <= '0;
                ent_rdy[e] <= '0;
            end
        end else begin
            for (int e = 0; e < IQ_DEPTH; e++) begin
                if (ent_state[e] == WAITING) begin
                    if (ent_age[e] != '1) begin
                        ent_age[e] <= ent_age[e] + 1'b1;
                    end
                    for (int k = 0; k < 2; k++) begin
                        if (i_wake_vld && ent_src[e][k] == i_wake_idx) begin
                            ent_rdy[e][k] <= 1'b1;
                        end
                    end
                end
                if (issue_mask[e]) begin
                    ent_state[e] <= FREE;
                end
            end
            if (disp_fire) begin
                ent_state[free_idx] <= WAITING;
                ent_age[free_idx] <= '0;
                ent_rdy[free_idx] <= {i_disp_use_imm || i_check_rdy[1], i_check_rdy[0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            ent_src[free_idx][0] <= i_disp_src1;
            ent_src[free_idx][1] <= i_disp_src2;
            ent_use_imm[free_idx] <= i_disp_use_imm;
            ent_imm[free_idx] <= i_disp_imm;
            ent_op[free_idx] <= i_disp_op;
            ent_dst[free_idx] <= i_disp_dst;
            ent_wen[free_idx] <= i_disp_wen;
            ent_rob[free_idx] <= i_disp_rob;
        end
    end

endmodule

`default_nettype wire

// File: alu/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input logic clk,
    input logic i_reset,
    issue_if.fu i_issue,
    wb_if.fu o_wb
);

    typedef enum logic [1:0] {
        ALU_IDLE,
        ALU_REQ,
        ALU_DROP
    } alu_state_e;

    alu_state_e state_q;
    exe_pkg::xdata_t result;
    exe_pkg::xdata_t result_q;
    exe_pkg::preg_idx_t dst_q;
    logic wen_q;
    exe_pkg::rob_idx_t rob_q;
    logic capture;

    always_comb begin
        case (i_issue.op)
            exe_pkg::ADD: result = i_issue.a + i_issue.b;
            exe_pkg::SUB: result = i_issue.a - i_issue.b;
            exe_pkg::AND: result = i_issue.a & i_issue.b;
            exe_pkg::OR:  result = i_issue.a | i_issue.b;
            exe_pkg::XOR: result = i_issue.a ^ i_issue.b;
            exe_pkg::SLL: result = i_issue.a << i_issue.b[4:0];
            exe_pkg::SRL: result = i_issue.a >> i_issue.b[4:0];
            exe_pkg::SLT: result = {{(exe_pkg::XLEN-1){1'b0}},
                                    $signed(i_issue.a) < $signed(i_issue.b)};
            default:      result = '0;
        endcase
    end

    assign capture = (state_q == ALU_IDLE) && i_issue.issue_vld;

    // req while in ALU_REQ, then wait out ack low
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= ALU_IDLE;
        end else begin
            case (state_q)
                ALU_IDLE: if (i_issue.issue_vld) state_q <= ALU_REQ;
                ALU_REQ:  if (o_wb.ack) state_q <= ALU_DROP;
                ALU_DROP: if (!o_wb.ack) state_q <= ALU_IDLE;
                default:  state_q <= ALU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            result_q <= result;
            dst_q <= i_issue.dst;
            wen_q <= i_issue.wen;
            rob_q <= i_issue.rob;
        end
    end

    assign i_issue.busy = (state_q != ALU_IDLE);
    assign o_wb.req = (state_q == ALU_REQ);
    assign o_wb.data = result_q;
    assign o_wb.dst = dst_q;
    assign o_wb.wen = wen_q;
    assign o_wb.rob = rob_q;

endmodule

`default_nettype wire

// File: verilog/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
    parameter int FU_NUM = 3
) (
    input logic clk,
    input logic i_reset,

    wb_if.arb i_wb [FU_NUM],

    // regfile write, also the wakeup
    output logic o_write_en,
    output exe_pkg::preg_idx_t o_write_idx,
    output exe_pkg::xdata_t o_write_data,

    output logic o_wb_valid,
    output exe_pkg::rob_idx_t o_wb_rob,
    output exe_pkg::preg_idx_t o_wb_dst,
    output logic o_wb_wen,
    output exe_pkg::xdata_t o_wb_data
);

    localparam int SEL_W = (FU_NUM > 1) ? $clog2(FU_NUM) : 1;

    typedef enum logic {
        ARB_IDLE,
        ARB_HOLD
    } arb_state_e;

    genvar f;

    arb_state_e state_q;
    logic [FU_NUM-1:0] req_vec;
    logic [FU_NUM-1:0] ack_q;
    exe_pkg::preg_idx_t dst_arr [FU_NUM];
    logic wen_arr [FU_NUM];
    exe_pkg::rob_idx_t rob_arr [FU_NUM];
    exe_pkg::xdata_t data_arr [FU_NUM];
    logic [SEL_W-1:0] ptr_q;
    logic [SEL_W-1:0] gnt_q;
    logic [SEL_W-1:0] pick;
    logic pick_vld;
    logic fire;

    generate
        for (f = 0; f < FU_NUM; f = f + 1) begin : gen_port
            assign req_vec[f] = i_wb[f].req;
            assign dst_arr[f] = i_wb[f].dst;
            assign wen_arr[f] = i_wb[f].wen;
            assign rob_arr[f] = i_wb[f].rob;
            assign data_arr[f] = i_wb[f].data;
            assign i_wb[f].ack = ack_q[f];
        end
    endgenerate

    // first requester at or after the pointer
    always_comb begin : rr_pick
        int idx;
        pick_vld = 1'b0;
        pick = '0;
        for (int k = FU_NUM - 1; k >= 0; k--) begin
            idx = int'(ptr_q) + k;
            if (idx >= FU_NUM) begin
                idx = idx - FU_NUM;
            end
            if (req_vec[idx]) begin
                pick_vld = 1'b1;
                pick = SEL_W'(idx);
            end
        end
    end

    assign fire = (state_q == ARB_IDLE) && pick_vld;
    assign o_write_en = fire && wen_arr[pick] && dst_arr[pick] != '0;
    assign o_write_idx = dst_arr[pick];
    assign o_write_data = data_arr[pick];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= ARB_IDLE;
            ack_q <= '0;
            ptr_q <= '0;
            gnt_q <= '0;
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= fire;
            case (state_q)
                ARB_IDLE: begin
                    if (fire) begin
                        ack_q <= FU_NUM'(1) << pick;
                        gnt_q <= pick;
                        ptr_q <= (int'(pick) == FU_NUM - 1) ? '0 : pick + 1'b1;
                        state_q <= ARB_HOLD;
                    end
                end
                ARB_HOLD: begin
                    // ack falls once the granted req has dropped
                    if (!req_vec[gnt_q]) begin
                        ack_q <= '0;
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            o_wb_rob <= rob_arr[pick];
            o_wb_dst <= dst_arr[pick];
            o_wb_wen <= wen_arr[pick];
            o_wb_data <= data_arr[pick];
        end
    end

endmodule

`default_nettype wire

// File: verilog/exe_block.sv
`timescale 1ns/1ps
`default_nettype none

module exe_block #(
    parameter int FU_NUM = 3,
    parameter int IQ_DEPTH = 8
) (
    input logic clk,
    input logic i_reset,

    // dispatch
    input logic i_disp_valid,
    output logic o_disp_ready,
    input exe_pkg::alu_op_e i_disp_op,
    input exe_pkg::preg_idx_t i_disp_src1,
    input exe_pkg::preg_idx_t i_disp_src2,
    input logic i_disp_use_imm,
    input exe_pkg::xdata_t i_disp_imm,
    input exe_pkg::preg_idx_t i_disp_dst,
    input logic i_disp_wen,
    input exe_pkg::rob_idx_t i_disp_rob,

    // completion to rob
    output logic o_wb_valid,
    output exe_pkg::rob_idx_t o_wb_rob,
    output exe_pkg::preg_idx_t o_wb_dst,
    output logic o_wb_wen,
    output exe_pkg::xdata_t o_wb_data
);

    genvar i;

    logic mark_vld;
    exe_pkg::preg_idx_t mark_idx;
    exe_pkg::preg_idx_t check_idx [2];
    logic [1:0] check_rdy;
    exe_pkg::preg_idx_t read_idx [2*FU_NUM];
    exe_pkg::xdata_t read_data [2*FU_NUM];
    logic write_en;
    exe_pkg::preg_idx_t write_idx;
    exe_pkg::xdata_t write_data;

    issue_if issue_bus [FU_NUM] ();
    wb_if wb_bus [FU_NUM] ();

    phys_regfile #(
        .FU_NUM ( FU_NUM )
    ) u_regfile (
        .clk          ( clk        ),
        .i_reset      ( i_reset    ),
        .i_mark_vld   ( mark_vld   ),
        .i_mark_idx   ( mark_idx   ),
        .i_check_idx  ( check_idx  ),
        .o_check_rdy  ( check_rdy  ),
        .i_read_idx   ( read_idx   ),
        .o_read_data  ( read_data  ),
        .i_write_en   ( write_en   ),
        .i_write_idx  ( write_idx  ),
        .i_write_data ( write_data )
    );

    issue_queue #(
        .FU_NUM   ( FU_NUM   ),
        .IQ_DEPTH ( IQ_DEPTH )
    ) u_issue_queue (
        .clk            ( clk            ),
        .i_reset        ( i_reset        ),
        .i_disp_valid   ( i_disp_valid   ),
        .o_disp_ready   ( o_disp_ready   ),
        .i_disp_op      ( i_disp_op      ),
        .i_disp_src1    ( i_disp_src1    ),
        .i_disp_src2    ( i_disp_src2    ),
        .i_disp_use_imm ( i_disp_use_imm ),
        .i_disp_imm     ( i_disp_imm     ),
        .i_disp_dst     ( i_disp_dst     ),
        .i_disp_wen     ( i_disp_wen     ),
        .i_disp_rob     ( i_disp_rob     ),
        .o_mark_vld     ( mark_vld       ),
        .o_mark_idx     ( mark_idx       ),
        .o_check_idx    ( check_idx      ),
        .i_check_rdy    ( check_rdy      ),
        .o_read_idx     ( read_idx       ),
        .i_read_data    ( read_data      ),
        .i_wake_vld     ( write_en       ),
        .i_wake_idx     ( write_idx      ),
        .o_issue        ( issue_bus      )
    );

    generate
        for (i = 0; i < FU_NUM; i = i + 1) begin : gen_alu
            alu_unit u_alu (
                .clk     ( clk          ),
                .i_reset ( i_reset      ),
                .i_issue ( issue_bus[i] ),
                .o_wb    ( wb_bus[i]    )
            );
        end
    endgenerate

    wb_arbiter #(
        .FU_NUM ( FU_NUM )
    ) u_wb_arbiter (
        .clk          ( clk        ),
        .i_reset      ( i_reset    ),
        .i_wb         ( wb_bus     ),
        .o_write_en   ( write_en   ),
        .o_write_idx  ( write_idx  ),
        .o_write_data ( write_data ),
        .o_wb_valid   ( o_wb_valid ),
        .o_wb_rob     ( o_wb_rob   ),
        .o_wb_dst     ( o_wb_dst   ),
        .o_wb_wen     ( o_wb_wen   ),
        .o_wb_data    ( o_wb_data  )
    );

endmodule

`default_nettype wire

// File: verification/exe_block_sva.sv
`timescale 1ns/1ps
`default_nettype none

module exe_block_sva #(
    parameter int FU_NUM = 3
) (
    input logic clk,
    input logic i_reset,
    input logic i_wb_valid,
    input exe_pkg::rob_idx_t i_wb_rob,
    input logic [FU_NUM-1:0] i_issue_vld,
    input logic [FU_NUM-1:0] i_req,
    input logic [FU_NUM-1:0] i_ack
);

    genvar g;

    // one pulse per completed result
    a_wb_once: assert property (@(posedge clk) disable iff (i_reset)
        i_wb_valid |=> !(i_wb_valid && i_wb_rob == $past(i_wb_rob)))
        else $error("o_wb_valid high two cycles in a row on one rob index");

    generate
        for (g = 0; g < FU_NUM; g = g + 1) begin : gen_fu
            a_req_held: assert property (@(posedge clk) disable iff (i_reset)
                i_req[g] && !i_ack[g] |=> i_req[g])
                else $error("alu %0d dropped req before ack", g);
            // a result still in its handshake keeps the alu busy
            a_issue_free: assert property (@(posedge clk) disable iff (i_reset)
                i_issue_vld[g] |-> (!i_req[g] && !i_ack[g]) ##1 !i_issue_vld[g])
                else $error("issue sent to busy alu %0d", g);
        end
    endgenerate

endmodule

`default_nettype wire

// File: verification/tb_exe_block.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exe_block;

    localparam int FU_NUM = 3;
    localparam int IQ_DEPTH = 8;
    localparam int N_SEED = 8;
    localparam int N_CHAIN = 60;
    localparam int N_OPS = 48;
    localparam int N_BURST = 64;
    localparam int N_ZERO = 24;
    localparam int TOTAL_OPS = N_SEED + N_CHAIN + N_OPS + N_BURST + N_ZERO;

    logic clk;
    logic i_reset;
    logic i_disp_valid;
    logic o_disp_ready;
    exe_pkg::alu_op_e i_disp_op;
    exe_pkg::preg_idx_t i_disp_src1;
    exe_pkg::preg_idx_t i_disp_src2;
    logic i_disp_use_imm;
    exe_pkg::xdata_t i_disp_imm;
    exe_pkg::preg_idx_t i_disp_dst;
    logic i_disp_wen;
    exe_pkg::rob_idx_t i_disp_rob;
    logic o_wb_valid;
    exe_pkg::rob_idx_t o_wb_rob;
    exe_pkg::preg_idx_t o_wb_dst;
    logic o_wb_wen;
    exe_pkg::xdata_t o_wb_data;

    integer seed;
    int err_cnt;
    int check_cnt;
    int stall_cnt;
    int inflight;
    exe_pkg::rob_idx_t next_rob;
    exe_pkg::preg_idx_t last_dst;

    // model values as they stand once every in-flight op is done
    exe_pkg::xdata_t model_val [32];
    logic pending [32];
    int rd_cnt [32];
    logic rob_busy [32];
    exe_pkg::xdata_t exp_data [32];
    exe_pkg::preg_idx_t exp_dst [32];
    logic exp_wen [32];
    exe_pkg::preg_idx_t used_src [32][2];
    logic used_imm [32];

    exe_block #(
        .FU_NUM   ( FU_NUM   ),
        .IQ_DEPTH ( IQ_DEPTH )
    ) exe_block_inst (
        .clk            ( clk            ),
        .i_reset        ( i_reset        ),
        .i_disp_valid   ( i_disp_valid   ),
        .o_disp_ready   ( o_disp_ready   ),
        .i_disp_op      ( i_disp_op      ),
        .i_disp_src1    ( i_disp_src1    ),
        .i_disp_src2    ( i_disp_src2    ),
        .i_disp_use_imm ( i_disp_use_imm ),
        .i_disp_imm     ( i_disp_imm     ),
        .i_disp_dst     ( i_disp_dst     ),
        .i_disp_wen     ( i_disp_wen     ),
        .i_disp_rob     ( i_disp_rob     ),
        .o_wb_valid     ( o_wb_valid     ),
        .o_wb_rob       ( o_wb_rob       ),
        .o_wb_dst       ( o_wb_dst       ),
        .o_wb_wen       ( o_wb_wen       ),
        .o_wb_data      ( o_wb_data      )
    );

    bind exe_block exe_block_sva #(
        .FU_NUM ( FU_NUM )
    ) u_sva (
        .clk         ( clk                     ),
        .i_reset     ( i_reset                 ),
        .i_wb_valid  ( o_wb_valid              ),
        .i_wb_rob    ( o_wb_rob                ),
        .i_issue_vld ( u_issue_queue.sel_vld   ),
        .i_req       ( u_wb_arbiter.req_vec    ),
        .i_ack       ( u_wb_arbiter.ack_q      )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic exe_pkg::xdata_t model_alu(input exe_pkg::alu_op_e op,
                                                  input exe_pkg::xdata_t a,
                                                  input exe_pkg::xdata_t b);
        case (op)
            exe_pkg::ADD: return a + b;
            exe_pkg::SUB: return a - b;
            exe_pkg::AND: return a & b;
            exe_pkg::OR:  return a | b;
            exe_pkg::XOR: return a ^ b;
            exe_pkg::SLL: return a << b[4:0];
            exe_pkg::SRL: return a >> b[4:0];
            // with signs that differ the negative one is smaller
            default: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        endcase
    endfunction

    function automatic exe_pkg::preg_idx_t pick_reg();
        return exe_pkg::preg_idx_t'($random(seed));
    endfunction

    task automatic check_field(input string name, input exe_pkg::rob_idx_t rob,
                               input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("ERR %0t %s rob %0d: got %0h expected %0h", $time, name, rob, got, exp);
        end
    endtask

    task automatic dispatch_op(input exe_pkg::alu_op_e op, input exe_pkg::preg_idx_t s1,
                               input exe_pkg::preg_idx_t s2, input logic use_imm,
                               input exe_pkg::xdata_t imm, input logic wen,
                               input logic to_zero);
        exe_pkg::preg_idx_t dst;
        exe_pkg::xdata_t b;
        logic found;
        logic took;
        logic wen_eff;
        int start;
        int r;
        rd_cnt[s1]++;
        if (!use_imm) begin
            rd_cnt[s2]++;
        end
        // rename to a register nobody waits on or still reads
        start = int'($unsigned($random(seed)) % 31);
        found = 1'b0;
        dst = exe_pkg::preg_idx_t'(1 + start);
        for (int k = 0; k < 31; k++) begin
            r = 1 + (start + k) % 31;
            if (!found && !pending[r] && rd_cnt[r] == 0) begin
                found = 1'b1;
                dst = exe_pkg::preg_idx_t'(r);
            end
        end
        wen_eff = wen && (found || to_zero);
        if (to_zero) begin
            dst = '0;
        end
        b = use_imm ? imm : model_val[s2];
        while (rob_busy[next_rob]) begin
            next_rob++;
        end
        rob_busy[next_rob] = 1'b1;
        exp_data[next_rob] = model_alu(op, model_val[s1], b);
        exp_dst[next_rob] = dst;
        exp_wen[next_rob] = wen_eff;
        used_src[next_rob][0] = s1;
        used_src[next_rob][1] = s2;
        used_imm[next_rob] = use_imm;
        if (wen_eff && dst != '0) begin
            pending[dst] = 1'b1;
            model_val[dst] = exp_data[next_rob];
        end
        last_dst = dst;
        inflight++;
        i_disp_valid <= 1'b1;
        i_disp_op <= op;
        i_disp_src1 <= s1;
        i_disp_src2 <= s2;
        i_disp_use_imm <= use_imm;
        i_disp_imm <= imm;
        i_disp_dst <= dst;
        i_disp_wen <= wen_eff;
        i_disp_rob <= next_rob;
        next_rob++;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = o_disp_ready;
            if (!took) begin
                stall_cnt++;
            end
            @(posedge clk);
        end
    endtask

    task automatic check_wb();
        exe_pkg::rob_idx_t r;
        r = o_wb_rob;
        check_cnt++;
        assert (rob_busy[r]) else begin
            err_cnt++;
            $display("writeback at %0t on rob %0d, which has no micro-op in flight", $time, r);
        end
        if (rob_busy[r]) begin
            check_field("o_wb_data", r, o_wb_data, exp_data[r]);
            check_field("o_wb_dst", r, 32'(o_wb_dst), 32'(exp_dst[r]));
            check_field("o_wb_wen", r, 32'(o_wb_wen), 32'(exp_wen[r]));
            rob_busy[r] = 1'b0;
            rd_cnt[used_src[r][0]]--;
            if (!used_imm[r]) begin
                rd_cnt[used_src[r][1]]--;
            end
            if (exp_wen[r] && exp_dst[r] != '0) begin
                pending[exp_dst[r]] = 1'b0;
            end
            inflight--;
        end
    endtask

    always @(negedge clk) begin
        if (!i_reset && o_wb_valid) begin
            check_wb();
        end
    end

    // mode 0 seeding, 1 chains, 2 every op, 3 burst, 4 r0 and disabled writes
    task automatic run_phase(input int mode, input int n, input string name);
        exe_pkg::alu_op_e op;
        exe_pkg::preg_idx_t s1;
        exe_pkg::preg_idx_t s2;
        exe_pkg::xdata_t imm;
        int e0;
        int s0;
        e0 = err_cnt;
        s0 = stall_cnt;
        for (int k = 0; k < n; k++) begin
            case (mode)
                0: dispatch_op(exe_pkg::ADD, '0, '0, 1'b1, $random(seed), 1'b1, 1'b0);
                1, 3: begin
                    op = exe_pkg::alu_op_e'(3'($random(seed)));
                    s1 = (($random(seed) & 3) != 0) ? last_dst : pick_reg();
                    s2 = (($random(seed) & 1) != 0) ? last_dst : pick_reg();
                    dispatch_op(op, s1, s2, ($random(seed) & 3) == 0, $random(seed),
                                1'b1, 1'b0);
                end
                2: begin
                    op = exe_pkg::alu_op_e'(3'(k));
                    imm = (k < 16) ? 32'd31 : (k < 32) ? 32'd63 : 32'h8000_0000;
                    dispatch_op(op, pick_reg(), pick_reg(), ((k / 8) % 2) == 0, imm,
                                1'b1, 1'b0);
                end
                default: begin
                    if (k % 3 == 0) begin
                        dispatch_op(exe_pkg::ADD, pick_reg(), '0, 1'b0, '0, 1'b1, 1'b1);
                    end else if (k % 3 == 1) begin
                        op = exe_pkg::alu_op_e'(3'($random(seed)));
                        dispatch_op(op, pick_reg(), pick_reg(), 1'b1, $random(seed),
                                    1'b0, 1'b0);
                    end else begin
                        // read back what the disabled write left alone
                        dispatch_op(exe_pkg::ADD, last_dst, '0, 1'b1, '0, 1'b1, 1'b0);
                    end
                end
            endcase
            if (mode == 1 && ($random(seed) & 3) == 0) begin
                i_disp_valid <= 1'b0;
                repeat (2) @(posedge clk);
            end
        end
        i_disp_valid <= 1'b0;
        while (inflight != 0) begin
            @(posedge clk);
        end
        if (mode == 3) begin
            check_cnt++;
            assert (stall_cnt > s0) else begin
                err_cnt++;
                $display("burst never filled the queue, o_disp_ready stayed high");
            end
        end
        $display("test %s: %0d micro-ops, %0d errors", name, n, err_cnt - e0);
    endtask

    initial begin
        repeat (TOTAL_OPS * 40 + 500) @(posedge clk);
        $display("timeout: run did not finish, %0d micro-ops still in flight", inflight);
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed = 21;
        err_cnt = 0;
        check_cnt = 0;
        stall_cnt = 0;
        inflight = 0;
        next_rob = '0;
        last_dst = '0;
        for (int r = 0; r < 32; r++) begin
            model_val[r] = '0;
            pending[r] = 1'b0;
            rd_cnt[r] = 0;
            rob_busy[r] = 1'b0;
        end
        i_reset = 1'b1;
        i_disp_valid = 1'b0;
        i_disp_op = exe_pkg::ADD;
        i_disp_src1 = '0;
        i_disp_src2 = '0;
        i_disp_use_imm = 1'b0;
        i_disp_imm = '0;
        i_disp_dst = '0;
        i_disp_wen = 1'b0;
        i_disp_rob = '0;
        repeat (5) @(posedge clk);
        i_reset <= 1'b0;
        @(posedge clk);
        run_phase(0, N_SEED, "immediate seeding");
        run_phase(1, N_CHAIN, "dependent chains");
        run_phase(2, N_OPS, "operation coverage");
        run_phase(3, N_BURST, "back-pressure");
        run_phase(4, N_ZERO, "register 0 and disabled writes");
        $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: exe_block.f
common/exe_pkg.sv
common/issue_if.sv
common/wb_if.sv
regfile/phys_regfile.sv
issue/issue_queue.sv
alu/alu_unit.sv
verilog/wb_arbiter.sv
verilog/exe_block.sv
verification/exe_block_sva.sv
verification/tb_exe_block.sv

// File: run_sim.sh
#!/bin/sh
# build and run the exe_block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exe_block -f exe_block.f \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_exe_block)
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1
